// ==== rtl/board_pkg.sv ====
/*
 * Shared board definitions for the coin-op controller.
 * Palette bases must be aligned to the palette window size,
 * as the decoder compares only the upper address bits.
 * Register addresses sit outside both palette windows.
 */
package board_pkg;

    // Bus region of the current CPU access
    typedef enum logic [2:0] {
        REG_NONE    = 3'd0,
        REG_PAL     = 3'd1,
        REG_LATCH   = 3'd2,
        REG_IRQ_ACK = 3'd3,
        REG_STATUS  = 3'd4,
        REG_CFG     = 3'd5
    } region_e;

    // Palette placement, taken from bit 0 of the header byte
    typedef enum logic {
        LAYOUT_A = 1'b0,
        LAYOUT_B = 1'b1
    } layout_e;

    localparam logic [15:0] PAL_BASE_A   = 16'h4000;
    localparam logic [15:0] PAL_BASE_B   = 16'h5800;

    // Board registers
    localparam logic [15:0] LATCH_ADDR   = 16'h5FC0;
    localparam logic [15:0] IRQ_ACK_ADDR = 16'h5FC4;
    localparam logic [15:0] STATUS_ADDR  = 16'h5FC8;
    localparam logic [15:0] CFG_ADDR     = 16'h5FCC;

endpackage

// ==== rtl/bus_decode.sv ====
/*
 * Address decoder, header capture and priority register.
 * The header byte is taken only at prog_addr 0 while header is high.
 * The palette window moves with the captured layout and spans 2**PAL_AW bytes.
 * Write strobes are combinational from cpu_wr.
 */
module bus_decode #(
    parameter int PAL_AW = 7
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [15:0]        cpu_addr,
    input  logic [7:0]         cpu_dout,
    input  logic               cpu_rd,
    input  logic               cpu_wr,
    input  logic [15:0]        prog_addr,
    input  logic [7:0]         prog_data,
    input  logic               prog_we,
    input  logic               header,
    output board_pkg::region_e region,
    output logic               pal_we,
    output logic [PAL_AW-1:0]  pal_addr,
    output logic               latch_we,
    output logic               irq_ack,
    output logic [1:0]         prio,
    output logic [7:0]         cfg_byte
);

    board_pkg::layout_e layout;
    logic [1:0]         game_id;
    logic [15:0]        pal_base;
    logic               pal_hit;
    logic               cfg_we;

    // Download header, first byte only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layout  <= board_pkg::LAYOUT_A;
            game_id <= 2'd0;
        end else if (prog_we && header && prog_addr == 16'd0) begin
            layout  <= board_pkg::layout_e'(prog_data[0]);
            game_id <= prog_data[2:1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio <= 2'd0;
        end else if (cfg_we) begin
            prio <= cpu_dout[1:0];
        end
    end

    assign pal_base = (layout == board_pkg::LAYOUT_B) ? board_pkg::PAL_BASE_B
                                                      : board_pkg::PAL_BASE_A;
    // Base is aligned, so the upper bits alone select the window
    assign pal_hit  = cpu_addr[15:PAL_AW] == pal_base[15:PAL_AW];

    always_comb begin
        if (pal_hit) begin
            region = board_pkg::REG_PAL;
        end else if (cpu_addr == board_pkg::LATCH_ADDR) begin
            region = board_pkg::REG_LATCH;
        end else if (cpu_addr == board_pkg::IRQ_ACK_ADDR) begin
            region = board_pkg::REG_IRQ_ACK;
        end else if (cpu_addr == board_pkg::STATUS_ADDR) begin
            region = board_pkg::REG_STATUS;
        end else if (cpu_addr == board_pkg::CFG_ADDR) begin
            region = board_pkg::REG_CFG;
        end else begin
            region = board_pkg::REG_NONE;
        end
    end

    assign pal_addr = cpu_addr[PAL_AW-1:0];
    assign pal_we   = cpu_wr && region == board_pkg::REG_PAL;
    assign latch_we = cpu_wr && region == board_pkg::REG_LATCH;
    assign irq_ack  = cpu_wr && region == board_pkg::REG_IRQ_ACK;
    assign cfg_we   = cpu_wr && region == board_pkg::REG_CFG;

    // game_id, zero, layout, two zeros, prio
    assign cfg_byte = {game_id, 1'b0, layout, 2'b00, prio};

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(cpu_rd && cpu_wr)
    );

    // Raw address hits, so a palette window over a register address shows up
    a_one_wr_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu_wr |-> $onehot0({pal_hit,
                             cpu_addr == board_pkg::LATCH_ADDR,
                             cpu_addr == board_pkg::IRQ_ACK_ADDR,
                             cpu_addr == board_pkg::CFG_ADDR})
    );

endmodule

// ==== rtl/palette_ram.sv ====
/*
 * Palette storage of 2**PAL_AW bytes.
 * Read is synchronous and runs every cycle, so pal_dout follows
 * pal_addr one cycle later. A read during a write returns the old byte.
 * Contents are undefined after power-up.
 */
module palette_ram #(
    parameter int PAL_AW = 7
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pal_we,
    input  logic [PAL_AW-1:0] pal_addr,
    input  logic [7:0]        cpu_dout,
    output logic [7:0]        pal_dout,
    output logic [7:0]        last_pal_idx
);

    localparam int DEPTH = 2 ** PAL_AW;

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (pal_we) begin
            mem[pal_addr] <= cpu_dout;
        end
        pal_dout <= mem[pal_addr];
    end

    // Index of the last written entry, for the debug view
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_pal_idx <= 8'd0;
        end else if (pal_we) begin
            last_pal_idx <= 8'(pal_addr);
        end
    end

endmodule

// ==== rtl/cpu_events.sv ====
/*
 * Sound latch and interrupt sources.
 * A latch write beats snd_ack in the same cycle.
 * The vblank interrupt fires on the falling edge of lvbl only
 * and stays pending until the CPU writes the ack address.
 */
module cpu_events (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       latch_we,
    input  logic       irq_ack,
    input  logic       snd_ack,
    input  logic [7:0] cpu_dout,
    input  logic       lvbl,
    output logic [7:0] snd_latch,
    output logic       snd_irq,
    output logic       irq_n,
    output logic [7:0] status_byte
);

    logic lvbl_l;
    logic vb_fall;
    logic vb_pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_latch <= 8'd0;
            snd_irq   <= 1'b0;
        end else if (latch_we) begin
            snd_latch <= cpu_dout;
            snd_irq   <= 1'b1;
        end else if (snd_ack) begin
            snd_irq   <= 1'b0;
        end
    end

    // Cleared at reset so a low lvbl at release does not fire
    assign vb_fall = lvbl_l && !lvbl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvbl_l  <= 1'b0;
            vb_pend <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (vb_fall) begin
                vb_pend <= 1'b1;
            end else if (irq_ack) begin
                vb_pend <= 1'b0;
            end
        end
    end

    assign irq_n       = !vb_pend;
    assign status_byte = {6'd0, vb_pend, snd_irq};

    a_irq_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> irq_n && !snd_irq
    );

endmodule

// ==== rtl/read_mux.sv ====
/*
 * CPU read data and debug byte.
 * Register sources are sampled at the cpu_rd edge, the palette byte
 * arrives one cycle later from the RAM. cpu_din holds until the next read.
 * Unmapped regions read as 0xFF.
 */
module read_mux (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_rd,
    input  board_pkg::region_e region,
    input  logic [7:0]         pal_dout,
    input  logic [7:0]         status_byte,
    input  logic [7:0]         cfg_byte,
    input  logic [7:0]         snd_latch,
    input  logic [7:0]         last_pal_idx,
    input  logic [1:0]         debug_sel,
    output logic [7:0]         cpu_din,
    output logic [7:0]         debug_view
);

    board_pkg::region_e rd_region;
    logic               rd_now;
    logic [7:0]         reg_q;
    logic [7:0]         sel_byte;
    logic [7:0]         din_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_region <= board_pkg::REG_NONE;
            rd_now    <= 1'b0;
            reg_q     <= 8'd0;
        end else begin
            rd_now <= cpu_rd;
            if (cpu_rd) begin
                rd_region <= region;
                case (region)
                    board_pkg::REG_STATUS: reg_q <= status_byte;
                    board_pkg::REG_CFG:    reg_q <= cfg_byte;
                    board_pkg::REG_LATCH:  reg_q <= snd_latch;
                    default:               reg_q <= 8'hFF;
                endcase
            end
        end
    end

    assign sel_byte = (rd_region == board_pkg::REG_PAL) ? pal_dout : reg_q;

    // Palette byte changes every cycle, so keep the value once the read is done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            din_q <= 8'd0;
        end else if (rd_now) begin
            din_q <= sel_byte;
        end
    end

    assign cpu_din = rd_now ? sel_byte : din_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_view <= 8'd0;
        end else begin
            case (debug_sel)
                2'd0:    debug_view <= snd_latch;
                2'd1:    debug_view <= status_byte;
                2'd2:    debug_view <= cfg_byte;
                default: debug_view <= last_pal_idx;
            endcase
        end
    end

    a_region_known: assert property (
        @(posedge clk) disable iff (!rst_n) cpu_rd |-> !$isunknown(region)
    );

endmodule

// ==== rtl/coin_board.sv ====
/*
 * Board glue between the main CPU and the board chips.
 * CPU strobes are single-cycle and never overlap.
 * Read data is valid one cycle after cpu_rd and holds until the next read.
 * PAL_AW may range up to 8.
 */
module coin_board #(
    parameter int PAL_AW = 7
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        cpu_rd,
    input  logic        cpu_wr,
    input  logic [15:0] prog_addr,
    input  logic [7:0]  prog_data,
    input  logic        prog_we,
    input  logic        header,
    input  logic        lvbl,
    input  logic        snd_ack,
    input  logic [1:0]  debug_sel,
    output logic [7:0]  cpu_din,
    output logic        irq_n,
    output logic [7:0]  snd_latch,
    output logic        snd_irq,
    output logic [1:0]  prio,
    output logic [7:0]  debug_view
);

    board_pkg::region_e  region;
    logic                pal_we;
    logic [PAL_AW-1:0]   pal_addr;
    logic                latch_we;
    logic                irq_ack;
    logic [7:0]          cfg_byte;
    logic [7:0]          pal_dout;
    logic [7:0]          last_pal_idx;
    logic [7:0]          status_byte;

    bus_decode #(
        .PAL_AW     ( PAL_AW    )
    ) u_decode (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .cpu_addr   ( cpu_addr  ),
        .cpu_dout   ( cpu_dout  ),
        .cpu_rd     ( cpu_rd    ),
        .cpu_wr     ( cpu_wr    ),
        .prog_addr  ( prog_addr ),
        .prog_data  ( prog_data ),
        .prog_we    ( prog_we   ),
        .header     ( header    ),
        .region     ( region    ),
        .pal_we     ( pal_we    ),
        .pal_addr   ( pal_addr  ),
        .latch_we   ( latch_we  ),
        .irq_ack    ( irq_ack   ),
        .prio       ( prio      ),
        .cfg_byte   ( cfg_byte  )
    );

    palette_ram #(
        .PAL_AW       ( PAL_AW       )
    ) u_palette (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pal_we       ( pal_we       ),
        .pal_addr     ( pal_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .pal_dout     ( pal_dout     ),
        .last_pal_idx ( last_pal_idx )
    );

    cpu_events u_events (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .latch_we    ( latch_we    ),
        .irq_ack     ( irq_ack     ),
        .snd_ack     ( snd_ack     ),
        .cpu_dout    ( cpu_dout    ),
        .lvbl        ( lvbl        ),
        .snd_latch   ( snd_latch   ),
        .snd_irq     ( snd_irq     ),
        .irq_n       ( irq_n       ),
        .status_byte ( status_byte )
    );

    read_mux u_rdmux (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cpu_rd       ( cpu_rd       ),
        .region       ( region       ),
        .pal_dout     ( pal_dout     ),
        .status_byte  ( status_byte  ),
        .cfg_byte     ( cfg_byte     ),
        .snd_latch    ( snd_latch    ),
        .last_pal_idx ( last_pal_idx ),
        .debug_sel    ( debug_sel    ),
        .cpu_din      ( cpu_din      ),
        .debug_view   ( debug_view   )
    );

endmodule

// ==== testbench/tb_coin_board.sv ====
/*
 * Directed testbench for coin_board with PAL_AW fixed at 7.
 * Inputs change 2 ns after the rising edge, outputs are checked there too.
 * The first failed check ends the run, as does the cycle limit.
 */
module tb_coin_board;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          PAL_AW         = 7;
    localparam logic [15:0] LFSR_SEED      = 16'd51580;
    localparam int          TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        rst_n;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic        cpu_rd;
    logic        cpu_wr;
    logic [15:0] prog_addr;
    logic [7:0]  prog_data;
    logic        prog_we;
    logic        header;
    logic        lvbl;
    logic        snd_ack;
    logic [1:0]  debug_sel;
    logic [7:0]  cpu_din;
    logic        irq_n;
    logic [7:0]  snd_latch;
    logic        snd_irq;
    logic [1:0]  prio;
    logic [7:0]  debug_view;

    logic [15:0]       lfsr;
    int                cycle_cnt;
    // Reference model of the board state
    logic [7:0]        pal_m [2**PAL_AW];
    logic [PAL_AW-1:0] last_idx_m;
    logic [7:0]        latch_m;
    logic              sirq_m;
    logic              vb_m;
    logic [1:0]        gid_m;
    logic              lay_m;
    logic [1:0]        prio_m;

    coin_board #(.PAL_AW(PAL_AW)) i_coin_board (
        .clk(clk), .rst_n(rst_n), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .prog_addr(prog_addr),
        .prog_data(prog_data), .prog_we(prog_we), .header(header), .lvbl(lvbl),
        .snd_ack(snd_ack), .debug_sel(debug_sel), .cpu_din(cpu_din),
        .irq_n(irq_n), .snd_latch(snd_latch), .snd_irq(snd_irq), .prio(prio),
        .debug_view(debug_view)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] r;
        r = 8'd0;
        for (int i = 0; i < 8; i++) begin
            r = {r[6:0], next_bit()};
        end
        return r;
    endfunction

    function automatic logic [PAL_AW-1:0] rand_index();
        logic [PAL_AW-1:0] r;
        r = '0;
        for (int i = 0; i < PAL_AW; i++) begin
            r = {r[PAL_AW-2:0], next_bit()};
        end
        return r;
    endfunction

    // game_id in 7:6, layout in 4, prio in 1:0
    function automatic logic [7:0] expect_cfg();
        return {gid_m, 1'b0, lay_m, 2'b00, prio_m};
    endfunction

    function automatic logic [7:0] expect_status();
        return {6'd0, vb_m, sirq_m};
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_wr   = 1'b1;
        step();
        cpu_wr   = 1'b0;
    endtask

    // Data is due one cycle after the strobe
    task automatic bus_read(input logic [15:0] addr, input logic [7:0] exp);
        cpu_addr = addr;
        cpu_rd   = 1'b1;
        step();
        cpu_rd   = 1'b0;
        check_value("cpu_din", cpu_din, exp);
    endtask

    task automatic load_header(input logic [7:0] data);
        prog_addr = 16'd0;
        prog_data = data;
        header    = 1'b1;
        prog_we   = 1'b1;
        step();
        prog_we   = 1'b0;
        header    = 1'b0;
        lay_m     = data[0];
        gid_m     = data[2:1];
    endtask

    task automatic test_reset_values();
        check_value("irq_n", {7'd0, irq_n}, 8'h01);
        check_value("snd_irq", {7'd0, snd_irq}, 8'h00);
        check_value("prio", {6'd0, prio}, 8'h00);
        bus_read(board_pkg::CFG_ADDR, 8'h00);
    endtask

    task automatic palette_pass(input logic [15:0] base, input logic [15:0] other);
        logic [PAL_AW-1:0] idx_list [16];
        logic [7:0]        data;
        for (int i = 0; i < 16; i++) begin
            idx_list[i] = rand_index();
            data = rand_byte();
            bus_write(base + {9'd0, idx_list[i]}, data);
            pal_m[idx_list[i]] = data;
            last_idx_m = idx_list[i];
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(base + {9'd0, idx_list[i]}, pal_m[idx_list[i]]);
        end
        // Window of the other layout is unmapped
        bus_read(other, 8'hFF);
        bus_read(board_pkg::CFG_ADDR, expect_cfg());
    endtask

    task automatic test_header_palette();
        load_header(8'h04);
        palette_pass(board_pkg::PAL_BASE_A, board_pkg::PAL_BASE_B);
        load_header(8'h03);
        palette_pass(board_pkg::PAL_BASE_B, board_pkg::PAL_BASE_A);
    endtask

    task automatic test_sound_latch();
        logic [7:0] data;
        data = rand_byte();
        bus_write(board_pkg::LATCH_ADDR, data);
        latch_m = data;
        sirq_m  = 1'b1;
        check_value("snd_latch", snd_latch, latch_m);
        check_value("snd_irq", {7'd0, snd_irq}, 8'h01);
        bus_read(board_pkg::STATUS_ADDR, expect_status());
        snd_ack = 1'b1;
        step();
        snd_ack = 1'b0;
        sirq_m  = 1'b0;
        check_value("snd_irq", {7'd0, snd_irq}, 8'h00);
        // Ack and write together, the write wins
        data    = rand_byte();
        snd_ack = 1'b1;
        bus_write(board_pkg::LATCH_ADDR, data);
        snd_ack = 1'b0;
        latch_m = data;
        sirq_m  = 1'b1;
        check_value("snd_irq", {7'd0, snd_irq}, 8'h01);
        check_value("snd_latch", snd_latch, latch_m);
        bus_read(board_pkg::STATUS_ADDR, expect_status());
        bus_read(board_pkg::LATCH_ADDR, latch_m);
    endtask

    task automatic test_vblank_irq();
        lvbl = 1'b0;
        step();
        vb_m = 1'b1;
        check_value("irq_n", {7'd0, irq_n}, 8'h00);
        bus_read(board_pkg::STATUS_ADDR, expect_status());
        bus_write(board_pkg::IRQ_ACK_ADDR, 8'h00);
        vb_m = 1'b0;
        check_value("irq_n", {7'd0, irq_n}, 8'h01);
        // lvbl still low, no new interrupt
        repeat (5) step();
        check_value("irq_n", {7'd0, irq_n}, 8'h01);
        bus_read(board_pkg::STATUS_ADDR, expect_status());
        lvbl = 1'b1;
        step();
    endtask

    task automatic test_prio_debug();
        logic [7:0] data;
        logic [7:0] exp;
        data = rand_byte();
        bus_write(board_pkg::CFG_ADDR, data);
        prio_m = data[1:0];
        check_value("prio", {6'd0, prio}, {6'd0, prio_m});
        bus_read(board_pkg::CFG_ADDR, expect_cfg());
        for (int sel = 0; sel < 4; sel++) begin
            debug_sel = 2'(sel);
            repeat (2) step();
            case (sel)
                0:       exp = latch_m;
                1:       exp = expect_status();
                2:       exp = expect_cfg();
                default: exp = {1'b0, last_idx_m};
            endcase
            check_value("debug_view", debug_view, exp);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cpu_addr  = 16'd0;
        cpu_dout  = 8'd0;
        cpu_rd    = 1'b0;
        cpu_wr    = 1'b0;
        prog_addr = 16'd0;
        prog_data = 8'd0;
        prog_we   = 1'b0;
        header    = 1'b0;
        lvbl      = 1'b1;
        snd_ack   = 1'b0;
        debug_sel = 2'd0;
        cycle_cnt = 0;
        lfsr      = LFSR_SEED;
        latch_m   = 8'd0;
        sirq_m    = 1'b0;
        vb_m      = 1'b0;
        gid_m     = 2'd0;
        lay_m     = 1'b0;
        prio_m    = 2'd0;
        last_idx_m = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();
        test_reset_values();
        test_header_palette();
        test_sound_latch();
        test_vblank_irq();
        test_prio_debug();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== coin_board.f ====
rtl/board_pkg.sv
rtl/bus_decode.sv
rtl/palette_ram.sv
rtl/cpu_events.sv
rtl/read_mux.sv
rtl/coin_board.sv
testbench/tb_coin_board.sv

// ==== Makefile ====
# Verilator build for the coin_board testbench

OBJ_DIR := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_coin_board \
		--Mdir $(OBJ_DIR) -f coin_board.f

run: compile
	./$(OBJ_DIR)/Vtb_coin_board

clean:
	rm -rf $(OBJ_DIR)
